// ==== common/wconv_params.svh ====
`ifndef WCONV_PARAMS_SVH
`define WCONV_PARAMS_SVH

// Write side carries one full word per push
`define WCONV_WR_W 32

// Read side hands out one byte per pop
`define WCONV_RD_W 8

// Byte address of the storage, 64 bytes or 16 words
`define WCONV_ADDR_W 6

// Bytes per write word
`define WCONV_LANES 4

`endif

// ==== common/wconv_pkg.sv ====
`include "wconv_params.svh"

package wconv_pkg;

   // One write word seen whole or as byte lanes, lane 0 is the LSB
   typedef union packed {
      logic [`WCONV_WR_W-1:0]                    word;
      logic [`WCONV_LANES-1:0][`WCONV_RD_W-1:0]  lane;
   } wide_word_u;

   // Level counts bytes and needs one bit above the address
   typedef struct packed {
      logic                   full;
      logic                   empty;
      logic [`WCONV_ADDR_W:0] level;
   } fifo_status_t;

   // Wide write into the RAM, byte address of lane 0
   typedef struct packed {
      logic                     en;
      logic [`WCONV_ADDR_W-1:0] addr;
      wide_word_u               data;
   } ram_wr_t;

   // Narrow read from the RAM
   typedef struct packed {
      logic                     en;
      logic [`WCONV_ADDR_W-1:0] addr;
   } ram_rd_t;

endpackage

// ==== source/dp_ram.sv ====
`timescale 1ns/1ns

module dp_ram #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 4
) (
   input  logic              clk_i,

   // Write port
   input  logic              wr_en_i,
   input  logic [ADDR_W-1:0] wr_addr_i,
   input  logic [DATA_W-1:0] wr_data_i,

   // Read port
   input  logic              rd_en_i,
   input  logic [ADDR_W-1:0] rd_addr_i,
   output logic [DATA_W-1:0] rd_data_o
);

   localparam int DEPTH = 2 ** ADDR_W;

   logic [DATA_W-1:0] mem [DEPTH];
   logic [DATA_W-1:0] rd_data_q;

   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // Output register holds the last read until the next enable
   always_ff @(posedge clk_i) begin
      if (rd_en_i) begin
         rd_data_q <= mem[rd_addr_i];
      end
   end

   assign rd_data_o = rd_data_q;

endmodule

// ==== asym_ram/asym_dp_ram.sv ====
`timescale 1ns/1ns

// Byte addressed on both ports, total size is 2^ADDR_W narrow items.
// Built from N symmetric blocks, N being the wide width over the narrow one.
module asym_dp_ram #(
   parameter int A_DATA_W = 32,
   parameter int B_DATA_W = 8,
   parameter int ADDR_W   = 6
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,

   // Port A writes only
   input  wconv_pkg::ram_wr_t    wr_i,

   // Port B reads only
   input  wconv_pkg::ram_rd_t    rd_i,
   output logic [B_DATA_W-1:0]   rd_data_o
);

   localparam int MAX_W      = (A_DATA_W > B_DATA_W) ? A_DATA_W : B_DATA_W;
   localparam int MIN_W      = (A_DATA_W < B_DATA_W) ? A_DATA_W : B_DATA_W;
   localparam int N          = MAX_W / MIN_W;
   localparam int N_W        = $clog2(N);
   localparam int SYMBOL_W   = $clog2(MIN_W / 8);
   localparam int BLK_ADDR_W = ADDR_W - N_W - SYMBOL_W;

   logic [A_DATA_W-1:0]         a_data;

   // Per block buses
   logic [N-1:0]                blk_wr_en;
   logic [N-1:0]                blk_rd_en;
   logic [N-1:0][MIN_W-1:0]     blk_wr_data;
   logic [N-1:0][MIN_W-1:0]     blk_rd_data;
   logic [BLK_ADDR_W-1:0]       blk_wr_addr;
   logic [BLK_ADDR_W-1:0]       blk_rd_addr;

   if (MAX_W % MIN_W != 0) begin : g_bad_ratio
      $error("asym_dp_ram: port widths must divide one another");
   end

   assign a_data = wr_i.data.word;

   // Blocks see the word address, lane and symbol bits stripped
   assign blk_wr_addr = wr_i.addr[ADDR_W-1 -: BLK_ADDR_W];
   assign blk_rd_addr = rd_i.addr[ADDR_W-1 -: BLK_ADDR_W];

   for (genvar i = 0; i < N; i++) begin : g_blk
      dp_ram #(
         .DATA_W(MIN_W),
         .ADDR_W(BLK_ADDR_W)
      ) u_dp_ram (
         .clk_i    (clk_i),
         .wr_en_i  (blk_wr_en[i]),
         .wr_addr_i(blk_wr_addr),
         .wr_data_i(blk_wr_data[i]),
         .rd_en_i  (blk_rd_en[i]),
         .rd_addr_i(blk_rd_addr),
         .rd_data_o(blk_rd_data[i])
      );
   end

   if (A_DATA_W > B_DATA_W) begin : g_wide_wr
      logic [N_W-1:0] rd_lane;
      logic [N_W-1:0] rd_sel_q;

      assign rd_lane = rd_i.addr[SYMBOL_W +: N_W];

      // Wide write goes to every block, slice i into block i
      assign blk_wr_en   = {N{wr_i.en}};
      assign blk_wr_data = a_data;

      // Only the addressed lane is read
      always_comb begin
         blk_rd_en          = '0;
         blk_rd_en[rd_lane] = rd_i.en;
      end

      // Lane follows the data through the read register
      always_ff @(posedge clk_i or negedge rst_n_i) begin
         if (!rst_n_i) begin
            rd_sel_q <= '0;
         end else if (rd_i.en) begin
            rd_sel_q <= rd_lane;
         end
      end

      assign rd_data_o = blk_rd_data[rd_sel_q];

   end else if (A_DATA_W < B_DATA_W) begin : g_wide_rd
      logic [N_W-1:0] wr_lane;

      assign wr_lane = wr_i.addr[SYMBOL_W +: N_W];

      // Narrow write lands only in its lane
      always_comb begin
         blk_wr_en          = '0;
         blk_wr_en[wr_lane] = wr_i.en;
      end

      assign blk_wr_data = {N{a_data}};

      // Wide read gathers all blocks, no selection needed
      assign blk_rd_en = {N{rd_i.en}};
      assign rd_data_o = blk_rd_data;

   end else begin : g_equal
      // Single block, ports pass straight through
      assign blk_wr_en   = wr_i.en;
      assign blk_wr_data = a_data;
      assign blk_rd_en   = rd_i.en;
      assign rd_data_o   = blk_rd_data;
   end

endmodule

// ==== source/fifo_ctrl.sv ====
`timescale 1ns/1ns

`include "wconv_params.svh"

module fifo_ctrl (
   input  logic                     clk_i,
   input  logic                     rst_n_i,

   // Write side, one word per push
   input  logic                     push_i,
   input  wconv_pkg::wide_word_u    wr_data_i,

   // Read side, one byte per pop
   input  logic                     pop_i,

   // RAM requests
   output wconv_pkg::ram_wr_t       ram_wr_o,
   output wconv_pkg::ram_rd_t       ram_rd_o,

   output logic                     rd_valid_o,
   output wconv_pkg::fifo_status_t  status_o
);

   localparam int ADDR_W     = `WCONV_ADDR_W;
   localparam int LANES      = `WCONV_LANES;
   localparam int LANE_BITS  = $clog2(LANES);
   localparam int WPTR_W     = ADDR_W - LANE_BITS;
   localparam int LEVEL_W    = ADDR_W + 1;
   localparam int DEPTH      = 2 ** ADDR_W;
   // A word still fits while at most this many bytes are held
   localparam int PUSH_LIMIT = DEPTH - LANES;

   logic [WPTR_W-1:0]  wr_ptr_q;
   logic [ADDR_W-1:0]  rd_ptr_q;
   logic [LEVEL_W-1:0] level_q;
   logic [LEVEL_W-1:0] level_next;
   logic               rd_valid_q;
   logic               push_ok;
   logic               pop_ok;

   // Strobes outside the limits are dropped
   assign push_ok = push_i && (level_q <= LEVEL_W'(PUSH_LIMIT));
   assign pop_ok  = pop_i && (level_q != '0);

   // Push adds a word, pop takes a byte, both gives +3
   always_comb begin
      level_next = level_q;
      if (push_ok) begin
         level_next = level_next + LEVEL_W'(LANES);
      end
      if (pop_ok) begin
         level_next = level_next - 1'b1;
      end
   end

   // Pointers wrap on their own width, level tells full from empty
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         level_q    <= '0;
         rd_valid_q <= 1'b0;
      end else begin
         if (push_ok) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop_ok) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         level_q    <= level_next;
         rd_valid_q <= pop_ok;
      end
   end

   // Word pointer scaled up to the byte address of lane 0
   assign ram_wr_o = '{
      en:   push_ok,
      addr: {wr_ptr_q, {LANE_BITS{1'b0}}},
      data: wr_data_i
   };

   assign ram_rd_o = '{
      en:   pop_ok,
      addr: rd_ptr_q
   };

   assign rd_valid_o = rd_valid_q;

   assign status_o = '{
      full:  (level_q > LEVEL_W'(PUSH_LIMIT)),
      empty: (level_q == '0),
      level: level_q
   };

endmodule

// ==== source/wconv_fifo.sv ====
`timescale 1ns/1ns

`include "wconv_params.svh"

module wconv_fifo (
   input  logic                     clk_i,
   input  logic                     rst_n_i,

   // Word write side
   input  logic                     push_i,
   input  wconv_pkg::wide_word_u    wr_data_i,

   // Byte read side
   input  logic                     pop_i,
   output logic [`WCONV_RD_W-1:0]   rd_data_o,
   output logic                     rd_valid_o,

   output wconv_pkg::fifo_status_t  status_o
);

   wconv_pkg::ram_wr_t ram_wr;
   wconv_pkg::ram_rd_t ram_rd;

   fifo_ctrl u_fifo_ctrl (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .push_i    (push_i),
      .wr_data_i (wr_data_i),
      .pop_i     (pop_i),
      .ram_wr_o  (ram_wr),
      .ram_rd_o  (ram_rd),
      .rd_valid_o(rd_valid_o),
      .status_o  (status_o)
   );

   // Wide on the write port, byte wide on the read port
   asym_dp_ram #(
      .A_DATA_W(`WCONV_WR_W),
      .B_DATA_W(`WCONV_RD_W),
      .ADDR_W  (`WCONV_ADDR_W)
   ) u_asym_dp_ram (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .wr_i     (ram_wr),
      .rd_i     (ram_rd),
      .rd_data_o(rd_data_o)
   );

endmodule

// ==== verification/wconv_fifo_props.sv ====
`timescale 1ns/1ns

`include "wconv_params.svh"

module wconv_fifo_props (
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   input  logic                     pop_i,
   input  logic                     rd_valid_o,
   input  wconv_pkg::fifo_status_t  status_o
);

   localparam int LEVEL_MAX = 1 << `WCONV_ADDR_W;

   // Running count of assertion failures
   int fail_count = 0;

   property no_full_and_empty;
      @(posedge clk_i) disable iff (!rst_n_i)
         !(status_o.full && status_o.empty);
   endproperty

   // Valid only ever follows a pop that found data
   property valid_after_pop;
      @(posedge clk_i) disable iff (!rst_n_i)
         rd_valid_o |-> $past(pop_i && (status_o.level != '0));
   endproperty

   property pop_gives_valid;
      @(posedge clk_i) disable iff (!rst_n_i)
         (pop_i && (status_o.level != '0)) |=> rd_valid_o;
   endproperty

   property level_in_range;
      @(posedge clk_i) disable iff (!rst_n_i)
         status_o.level <= LEVEL_MAX;
   endproperty

   a_no_full_and_empty: assert property (no_full_and_empty)
      else begin
         $error("full and empty are high together");
         fail_count++;
      end

   a_valid_after_pop: assert property (valid_after_pop)
      else begin
         $error("rd_valid_o high without an accepted pop");
         fail_count++;
      end

   a_pop_gives_valid: assert property (pop_gives_valid)
      else begin
         $error("accepted pop not followed by rd_valid_o");
         fail_count++;
      end

   a_level_in_range: assert property (level_in_range)
      else begin
         $error("level above the storage size");
         fail_count++;
      end

endmodule

bind wconv_fifo wconv_fifo_props u_wconv_fifo_props (
   .clk_i     (clk_i),
   .rst_n_i   (rst_n_i),
   .pop_i     (pop_i),
   .rd_valid_o(rd_valid_o),
   .status_o  (status_o)
);

// ==== verification/wconv_fifo_tb.sv ====
`timescale 1ns/1ns

`include "wconv_params.svh"

module wconv_fifo_tb;

   localparam int DEPTH         = 1 << `WCONV_ADDR_W;
   localparam int LANES         = `WCONV_LANES;
   localparam int PUSH_LIMIT    = DEPTH - LANES;
   localparam int RANDOM_CYCLES = 300;
   // Well above the combined length of all tests
   localparam int MAX_CYCLES    = 3000;

   logic                     clk;
   logic                     rst_n;
   logic                     push;
   wconv_pkg::wide_word_u    wr_data;
   logic                     pop;
   logic [`WCONV_RD_W-1:0]   rd_data;
   logic                     rd_valid;
   wconv_pkg::fifo_status_t  status;

   logic [7:0] model_q[$];
   string      cur_test;
   int         test_errors;
   int         total_errors;
   int         tests_run;
   int         tests_failed;
   int         cycle_cnt;

   wconv_fifo u_wconv_fifo (
      .clk_i     (clk),
      .rst_n_i   (rst_n),
      .push_i    (push),
      .wr_data_i (wr_data),
      .pop_i     (pop),
      .rd_data_o (rd_data),
      .rd_valid_o(rd_valid),
      .status_o  (status)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
         $display("=== FAIL ===");
         $finish;
      end
   end

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         $display("** Error [%s] %s: expected %0h, actual %0h",
                  cur_test, what, expected, actual);
         test_errors++;
      end
   endtask

   task automatic start_test(input string name);
      cur_test    = name;
      test_errors = 0;
   endtask

   task automatic close_test();
      tests_run++;
      total_errors += test_errors;
      if (test_errors == 0) begin
         $display("%s: ok", cur_test);
      end else begin
         tests_failed++;
         $display("%s: %0d mismatches", cur_test, test_errors);
      end
   endtask

   // Compare status and read port against the byte queue
   task automatic check_outputs(input logic exp_valid, input logic [7:0] exp_byte);
      check_value("rd_valid_o", exp_valid, rd_valid);
      if (exp_valid) begin
         check_value("rd_data_o", exp_byte, rd_data);
      end
      check_value("level", model_q.size(), status.level);
      check_value("empty", model_q.size() == 0, status.empty);
      check_value("full", model_q.size() > PUSH_LIMIT, status.full);
   endtask

   // Starts and ends on a falling edge
   task automatic run_cycle(input logic do_push, input logic [31:0] data,
                            input logic do_pop);
      logic                  push_ok;
      logic                  pop_ok;
      logic [7:0]            exp_byte;
      wconv_pkg::wide_word_u pushed;
      push         = do_push;
      wr_data.word = data;
      pop          = do_pop;
      push_ok      = do_push && (model_q.size() <= PUSH_LIMIT);
      pop_ok       = do_pop && (model_q.size() != 0);
      exp_byte     = '0;
      pushed.word  = data;
      @(posedge clk);
      if (pop_ok) begin
         exp_byte = model_q.pop_front();
      end
      // Lane 0 leaves first
      if (push_ok) begin
         for (int i = 0; i < LANES; i++) begin
            model_q.push_back(pushed.lane[i]);
         end
      end
      @(negedge clk);
      push = 1'b0;
      pop  = 1'b0;
      check_outputs(pop_ok, exp_byte);
   endtask

   task automatic test_reset();
      start_test("test_reset");
      check_outputs(1'b0, 8'h00);
      close_test();
   endtask

   task automatic test_single_word();
      start_test("test_single_word");
      run_cycle(1'b1, 32'ha1b2_c3d4, 1'b0);
      repeat (LANES) run_cycle(1'b0, '0, 1'b1);
      run_cycle(1'b0, '0, 1'b0);
      close_test();
   endtask

   task automatic test_fill_drain();
      start_test("test_fill_drain");
      for (int w = 0; w < DEPTH / LANES; w++) begin
         run_cycle(1'b1, $urandom, 1'b0);
      end
      check_value("level after fill", DEPTH, status.level);
      check_value("full after fill", 1, status.full);
      // No room left, this word is dropped
      run_cycle(1'b1, 32'hdead_beef, 1'b0);
      check_value("level after extra push", DEPTH, status.level);
      repeat (DEPTH) run_cycle(1'b0, '0, 1'b1);
      run_cycle(1'b0, '0, 1'b0);
      close_test();
   endtask

   task automatic test_underflow();
      start_test("test_underflow");
      run_cycle(1'b0, '0, 1'b1);
      run_cycle(1'b1, 32'h0f1e_2d3c, 1'b0);
      run_cycle(1'b0, '0, 1'b1);
      repeat (LANES - 1) run_cycle(1'b0, '0, 1'b1);
      run_cycle(1'b0, '0, 1'b1);
      close_test();
   endtask

   task automatic test_random_mix();
      int   push_pct;
      logic do_push;
      logic do_pop;
      start_test("test_random_mix");
      // Push rate drops halfway through so the level falls again
      for (int c = 0; c < RANDOM_CYCLES; c++) begin
         push_pct = (c < RANDOM_CYCLES / 2) ? 40 : 10;
         do_push  = ($urandom % 100) < push_pct;
         do_pop   = ($urandom % 100) < 70;
         run_cycle(do_push, $urandom, do_pop);
      end
      close_test();
   endtask

   initial begin
      int assert_fails;
      void'($urandom(32'h4c7b_c34b));
      cycle_cnt    = 0;
      total_errors = 0;
      tests_run    = 0;
      tests_failed = 0;
      rst_n        = 1'b0;
      push         = 1'b0;
      pop          = 1'b0;
      wr_data.word = '0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      test_reset();
      test_single_word();
      test_fill_drain();
      test_underflow();
      test_random_mix();

      assert_fails = u_wconv_fifo.u_wconv_fifo_props.fail_count;
      $display("Tests run: %0d, failed: %0d, errors: %0d, assertion failures: %0d",
               tests_run, tests_failed, total_errors, assert_fails);
      if (total_errors == 0 && tests_failed == 0 && assert_fails == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+common
common/wconv_pkg.sv
source/dp_ram.sv
asym_ram/asym_dp_ram.sv
source/fifo_ctrl.sv
source/wconv_fifo.sv
verification/wconv_fifo_props.sv
verification/wconv_fifo_tb.sv

// ==== Bender.yml ====
package:
  name: wconv_fifo

sources:
  # Shared types and the design
  - include_dirs:
      - common
    files:
      - common/wconv_pkg.sv
      - source/dp_ram.sv
      - asym_ram/asym_dp_ram.sv
      - source/fifo_ctrl.sv
      - source/wconv_fifo.sv

  # Simulation only
  - target: test
    include_dirs:
      - common
    files:
      - verification/wconv_fifo_props.sv
      - verification/wconv_fifo_tb.sv
